/* src/link_fifo_config.svh */
// sizing macros for the link-to-fifo subsystem, included by the package and every module
`ifndef LINK_FIFO_CONFIG_SVH
`define LINK_FIFO_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// packet field widths
////////////////////////////////////////////////////////////////////////////

// byte address carried by a mesh packet
`define LF_ADDR_W 16

// data width of one lane
`define LF_DATA_W 32

// mesh coordinate widths
`define LF_X_W 4
`define LF_Y_W 4

////////////////////////////////////////////////////////////////////////////
// topology
////////////////////////////////////////////////////////////////////////////

// lanes joined side by side into one output word
`define LF_LANES 2

// channels taking turns on the output port
`define LF_CHANNELS 2

// total mesh links, channel-major
`define LF_LINKS (`LF_LANES * `LF_CHANNELS)

// endpoint packet buffer, equal to the credits the sender starts with
`define LF_EP_DEPTH 4

`endif

/* src/link_fifo_pkg.sv */
// shared packet, link and output word types, imported by every module of the subsystem
`include "link_fifo_config.svh"

package link_fifo_pkg;

  // one lane of payload
  typedef logic [`LF_DATA_W-1:0] lane_word_t;

  // full output word, lane 0 sits in the low bits
  typedef lane_word_t [`LF_LANES-1:0] out_word_t;

  // packet opcode
  typedef enum logic {
    LINK_OP_WRITE = 1'b0,
    LINK_OP_READ  = 1'b1
  } link_op_e;

  // mesh packet as it arrives on a link
  typedef struct packed {
    link_op_e               op;
    logic [`LF_ADDR_W-1:0]  addr;
    lane_word_t             data;
    logic [`LF_X_W-1:0]     dst_x;
    logic [`LF_Y_W-1:0]     dst_y;
    logic [`LF_X_W-1:0]     src_x;
    logic [`LF_Y_W-1:0]     src_y;
  } link_packet_t;

  // mesh to endpoint
  typedef struct packed {
    logic         v;
    link_packet_t pkt;
  } link_fwd_t;

  // endpoint back to mesh, one pulse per freed buffer slot
  typedef struct packed {
    logic credit;
  } link_rev_t;

endpackage

/* src/relay_fifo.sv */
// two-entry valid/ready buffer that cuts the ready path, reused for lane and full words
`timescale 1ns/10ps

module relay_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     ready_i
);

  payload_t   mem [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;

  logic       push;
  logic       pop;

  // both flags come straight from the count register
  assign ready_o = (count_q != 2'd2);
  assign v_o     = (count_q != 2'd0);
  assign data_o  = mem[rd_ptr_q];

  assign push = v_i & ready_o;
  assign pop  = v_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* src/rr_arbiter.sv */
// strict round-robin n-to-1 selector, pointer moves past the winner on each yumi
`timescale 1ns/10ps

module rr_arbiter #(
  parameter int  NUM_IN    = 2,
  parameter type payload_t = logic
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [NUM_IN-1:0]          v_i,
  input  payload_t [NUM_IN-1:0]      data_i,
  output logic [NUM_IN-1:0]          yumi_o,
  output logic                       v_o,
  output payload_t                   data_o,
  input  logic                       yumi_i
);

  localparam int PTR_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

  logic [PTR_W-1:0]  ptr_q;
  logic [PTR_W-1:0]  win_idx;
  logic [NUM_IN-1:0] grant;
  logic              found;

  ////////////////////////////////////////////////////////////////////////////
  // grant search
  ////////////////////////////////////////////////////////////////////////////

  // first valid input at or after the pointer
  always_comb begin
    int cand;
    grant   = '0;
    win_idx = ptr_q;
    found   = 1'b0;
    cand    = 0;
    for (int k = 0; k < NUM_IN; k++) begin
      cand = int'(ptr_q) + k;
      if (cand >= NUM_IN) begin
        cand = cand - NUM_IN;
      end
      if (!found && v_i[cand]) begin
        found   = 1'b1;
        win_idx = PTR_W'(cand);
      end
    end
    grant[win_idx] = found;
  end

  assign v_o    = found;
  assign data_o = data_i[win_idx];
  assign yumi_o = grant & {NUM_IN{yumi_i}};

  ////////////////////////////////////////////////////////////////////////////
  // pointer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (yumi_i) begin
      // winner drops to lowest priority
      if (win_idx == PTR_W'(NUM_IN - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win_idx + 1'b1;
      end
    end
  end

endmodule

/* src/lane_merger.sv */
// joins the lanes of one channel into a full output word, moving all lanes in one cycle
`timescale 1ns/10ps
`include "link_fifo_config.svh"

module lane_merger
  import link_fifo_pkg::*;
(
  input  logic [`LF_LANES-1:0]       v_i,
  input  lane_word_t [`LF_LANES-1:0] data_i,
  output logic [`LF_LANES-1:0]       ready_o,
  output logic                       v_o,
  input  logic                       ready_i,
  output out_word_t                  data_o
);

  logic fire;

  ////////////////////////////////////////////////////////////////////////////
  // alignment
  ////////////////////////////////////////////////////////////////////////////

  // word exists only once every lane holds its part
  assign v_o = &v_i;

  // shared acknowledge keeps the lanes in step
  assign fire = v_o & ready_i;

  assign ready_o = {`LF_LANES{fire}};

  ////////////////////////////////////////////////////////////////////////////
  // data packing
  ////////////////////////////////////////////////////////////////////////////

  // lane j lands in slice j, lane 0 lowest
  for (genvar j = 0; j < `LF_LANES; j++) begin : g_lane
    assign data_o[j] = data_i[j];
  end

endmodule

/* src/link_endpoint.sv */
// mesh link receiver, buffers packets, filters on opcode and destination, returns credits
`timescale 1ns/10ps
`include "link_fifo_config.svh"

module link_endpoint
  import link_fifo_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  link_fwd_t          link_i,
  output link_rev_t          link_o,
  input  logic [`LF_X_W-1:0] my_x_i,
  input  logic [`LF_Y_W-1:0] my_y_i,
  output logic               v_o,
  output lane_word_t         data_o,
  input  logic               ready_i,
  output logic               drop_o
);

  localparam int PTR_W = $clog2(`LF_EP_DEPTH);
  localparam int CNT_W = $clog2(`LF_EP_DEPTH + 1);

  link_packet_t         buf_mem [`LF_EP_DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;
  logic                 drop_q;

  link_packet_t         head;
  logic                 not_empty;
  logic                 head_ok;
  logic                 drop_pop;
  logic                 pop;

  // packet buffer, sender credits keep it from overflowing
  always_ff @(posedge clk_i) begin
    if (link_i.v) begin
      buf_mem[wr_ptr_q] <= link_i.pkt;
    end
  end

  assign head      = buf_mem[rd_ptr_q];
  assign not_empty = (count_q != '0);

  // only writes aimed at this tile go on
  assign head_ok = (head.op == LINK_OP_WRITE) &&
                   (head.dst_x == my_x_i) && (head.dst_y == my_y_i);

  assign v_o      = not_empty & head_ok;
  assign data_o   = head.data;
  assign drop_pop = not_empty & ~head_ok;
  assign pop      = drop_pop | (v_o & ready_i);

  // a slot freed either way gives back one credit
  assign link_o.credit = pop;
  assign drop_o        = drop_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      drop_q   <= 1'b0;
    end else begin
      if (link_i.v) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`LF_EP_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`LF_EP_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(link_i.v) - CNT_W'(pop);
      // sticky until reset
      if (drop_pop) begin
        drop_q <= 1'b1;
      end
    end
  end

endmodule

/* src/link_to_fifo.sv */
// top level, merges mesh write traffic from all links into one wide valid/ready stream
`timescale 1ns/10ps
`include "link_fifo_config.svh"

module link_to_fifo
  import link_fifo_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  link_fwd_t [`LF_LINKS-1:0]           link_i,
  output link_rev_t [`LF_LINKS-1:0]           link_o,
  input  logic [`LF_LINKS-1:0][`LF_X_W-1:0]   my_x_i,
  input  logic [`LF_LINKS-1:0][`LF_Y_W-1:0]   my_y_i,
  output logic                                v_o,
  output out_word_t                           data_o,
  input  logic                                ready_i,
  output logic                                drop_o
);

  // endpoint outputs
  logic [`LF_LINKS-1:0]          ep_v;
  logic [`LF_LINKS-1:0]          ep_ready;
  lane_word_t [`LF_LINKS-1:0]    ep_data;
  logic [`LF_LINKS-1:0]          ep_drop;

  // lane relay outputs
  logic [`LF_LINKS-1:0]          lane_v;
  logic [`LF_LINKS-1:0]          lane_ready;
  lane_word_t [`LF_LINKS-1:0]    lane_data;

  // merged words and their buffers
  logic [`LF_CHANNELS-1:0]       merged_v;
  logic [`LF_CHANNELS-1:0]       merged_ready;
  out_word_t [`LF_CHANNELS-1:0]  merged_data;
  logic [`LF_CHANNELS-1:0]       chan_v;
  logic [`LF_CHANNELS-1:0]       chan_yumi;
  out_word_t [`LF_CHANNELS-1:0]  chan_data;

  // arbiter to output relay
  logic                          rr_v;
  out_word_t                     rr_data;
  logic                          rr_ready;
  logic                          rr_yumi;

  ////////////////////////////////////////////////////////////////////////////
  // per link: endpoint and lane relay
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `LF_LINKS; i++) begin : g_link
    link_endpoint ep_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .link_i  (link_i[i]),
      .link_o  (link_o[i]),
      .my_x_i  (my_x_i[i]),
      .my_y_i  (my_y_i[i]),
      .v_o     (ep_v[i]),
      .data_o  (ep_data[i]),
      .ready_i (ep_ready[i]),
      .drop_o  (ep_drop[i])
    );

    relay_fifo #(.payload_t(lane_word_t)) lane_relay_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .v_i     (ep_v[i]),
      .data_i  (ep_data[i]),
      .ready_o (ep_ready[i]),
      .v_o     (lane_v[i]),
      .data_o  (lane_data[i]),
      .ready_i (lane_ready[i])
    );
  end

  assign drop_o = |ep_drop;

  ////////////////////////////////////////////////////////////////////////////
  // per channel: merge lanes, then buffer the wide word
  ////////////////////////////////////////////////////////////////////////////

  // link index is channel * lanes + lane
  for (genvar c = 0; c < `LF_CHANNELS; c++) begin : g_chan
    lane_merger merger_inst (
      .v_i     (lane_v[c*`LF_LANES +: `LF_LANES]),
      .data_i  (lane_data[c*`LF_LANES +: `LF_LANES]),
      .ready_o (lane_ready[c*`LF_LANES +: `LF_LANES]),
      .v_o     (merged_v[c]),
      .ready_i (merged_ready[c]),
      .data_o  (merged_data[c])
    );

    relay_fifo #(.payload_t(out_word_t)) chan_relay_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .v_i     (merged_v[c]),
      .data_i  (merged_data[c]),
      .ready_o (merged_ready[c]),
      .v_o     (chan_v[c]),
      .data_o  (chan_data[c]),
      .ready_i (chan_yumi[c])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // channel arbitration and output buffer
  ////////////////////////////////////////////////////////////////////////////

  rr_arbiter #(
    .NUM_IN    (`LF_CHANNELS),
    .payload_t (out_word_t)
  ) rr_inst (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .v_i    (chan_v),
    .data_i (chan_data),
    .yumi_o (chan_yumi),
    .v_o    (rr_v),
    .data_o (rr_data),
    .yumi_i (rr_yumi)
  );

  assign rr_yumi = rr_v & rr_ready;

  relay_fifo #(.payload_t(out_word_t)) out_relay_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .v_i     (rr_v),
    .data_i  (rr_data),
    .ready_o (rr_ready),
    .v_o     (v_o),
    .data_o  (data_o),
    .ready_i (ready_i)
  );

endmodule

/* sim/link_to_fifo_tb.sv */
// plays the mesh sender with credits for the link-to-fifo top level and checks its output stream
`timescale 1ns/10ps
`include "link_fifo_config.svh"

module link_to_fifo_tb
  import link_fifo_pkg::*;
();

  localparam int LANES = `LF_LANES;
  localparam int CHANS = `LF_CHANNELS;
  localparam int LINKS = `LF_LINKS;
  localparam int DEPTH = `LF_EP_DEPTH;

  logic                          clk;
  logic                          rst;
  link_fwd_t [LINKS-1:0]         link_fwd;
  link_rev_t [LINKS-1:0]         link_rev;
  logic [LINKS-1:0][`LF_X_W-1:0] my_x;
  logic [LINKS-1:0][`LF_Y_W-1:0] my_y;
  logic                          out_v;
  out_word_t                     out_data;
  logic                          out_ready;
  logic                          drop;

  // sender state owned by the stimulus process
  int        spent [LINKS];
  int        drv_seq [CHANS];
  int        bit_errs;
  int        timeouts;
  // monitor state
  int        returned [LINKS];
  int        mon_seq [CHANS];
  int        word_errs;
  out_word_t exp_q [CHANS][$];
  logic      held_v;
  out_word_t held_data;

  link_to_fifo link_to_fifo_inst (
    .clk_i   (clk),
    .rst_i   (rst),
    .link_i  (link_fwd),
    .link_o  (link_rev),
    .my_x_i  (my_x),
    .my_y_i  (my_y),
    .v_o     (out_v),
    .data_o  (out_data),
    .ready_i (out_ready),
    .drop_o  (drop)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // lane payload is channel, lane, sequence from msb down
  function automatic lane_word_t lane_data(input int chan, input int lane, input int seq);
    return {8'(chan), 8'(lane), 16'(seq)};
  endfunction

  // lanes of one channel side by side with lane 0 lowest
  function automatic out_word_t expected_word(input int chan, input int seq);
    out_word_t w;
    for (int l = 0; l < LANES; l++) begin
      w[l] = lane_data(chan, l, seq);
    end
    return w;
  endfunction

  function automatic int credits(input int idx);
    return DEPTH - spent[idx] + returned[idx];
  endfunction

  // kind 0 is a good write, 1 a read, 2 a write for another tile
  function automatic link_packet_t make_pkt(input int kind, input int idx, input lane_word_t d);
    link_packet_t p;
    p       = '0;
    p.op    = (kind == 1) ? LINK_OP_READ : LINK_OP_WRITE;
    p.addr  = d[`LF_ADDR_W-1:0];
    p.data  = d;
    p.dst_x = (kind == 2) ? ~my_x[idx] : my_x[idx];
    p.dst_y = my_y[idx];
    return p;
  endfunction

  task automatic check_word(input out_word_t got, input out_word_t exp, input string what);
    if (got !== exp) begin
      word_errs++;
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      bit_errs++;
      $display("Error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output monitor, credit return and expected words
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    int chan;
    int idx;
    if (!rst) begin
      // a stalled word has to stay put
      if (held_v) begin
        if (out_v !== 1'b1) begin
          word_errs++;
          $display("Error at %0t ns: v_o fell while ready_i was low", $time);
        end
        check_word(out_data, held_data, "data_o under back-pressure");
      end
      if (out_v && out_ready) begin
        chan = int'(out_data[0][`LF_DATA_W-1 -: 8]);
        if (chan >= CHANS || exp_q[chan].size() == 0) begin
          word_errs++;
          $display("Error at %0t ns: unexpected output word %h", $time, out_data);
        end else begin
          check_word(out_data, exp_q[chan].pop_front(), "output word");
        end
      end
      for (int i = 0; i < LINKS; i++) begin
        if (link_rev[i].credit) begin
          returned[i]++;
        end
      end
      // one word expected per deliverable write on a channel
      for (int c = 0; c < CHANS; c++) begin
        idx = c * LANES;
        if (link_fwd[idx].v && link_fwd[idx].pkt.op == LINK_OP_WRITE &&
            link_fwd[idx].pkt.dst_x == my_x[idx] && link_fwd[idx].pkt.dst_y == my_y[idx]) begin
          exp_q[c].push_back(expected_word(c, mon_seq[c]));
          mon_seq[c]++;
        end
      end
    end
    held_v    = !rst && out_v && !out_ready;
    held_data = out_data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_words(input logic [CHANS-1:0] mask, input int n_words,
                            input int stall_pct, input bit with_drops);
    int left [CHANS];
    int kind;
    int idx;
    int cycles;
    bit busy;
    bit room;
    for (int c = 0; c < CHANS; c++) begin
      left[c] = mask[c] ? n_words : 0;
    end
    busy   = 1'b1;
    cycles = 0;
    while (busy && cycles < n_words * 50 + 100) begin
      @(negedge clk);
      cycles++;
      out_ready = ($urandom_range(99) >= stall_pct);
      link_fwd  = '0;
      busy      = 1'b0;
      for (int c = 0; c < CHANS; c++) begin
        room = 1'b1;
        for (int l = 0; l < LANES; l++) begin
          if (credits(c * LANES + l) == 0) begin
            room = 1'b0;
          end
        end
        if (left[c] > 0 && room && $urandom_range(3) != 0) begin
          kind = with_drops ? left[c] % 3 : 0;
          for (int l = 0; l < LANES; l++) begin
            idx = c * LANES + l;
            link_fwd[idx].v   = 1'b1;
            link_fwd[idx].pkt = make_pkt(kind, idx, lane_data(c, l, drv_seq[c]));
            spent[idx]++;
          end
          if (kind == 0) begin
            drv_seq[c]++;
          end
          left[c]--;
        end
        if (left[c] > 0) begin
          busy = 1'b1;
        end
      end
    end
    @(negedge clk);
    link_fwd = '0;
    if (busy) begin
      timeouts++;
      $display("Timeout: sender still held unsent words after %0d cycles", cycles);
    end
  endtask

  // wait until every expected word is out and every credit is back
  task automatic drain(input string phase);
    int cycles;
    bit done;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < 400) begin
      @(negedge clk);
      out_ready = 1'b1;
      cycles++;
      done = 1'b1;
      for (int c = 0; c < CHANS; c++) begin
        if (exp_q[c].size() != 0) begin
          done = 1'b0;
        end
      end
      for (int i = 0; i < LINKS; i++) begin
        if (credits(i) != DEPTH) begin
          done = 1'b0;
        end
      end
    end
    if (!done) begin
      timeouts++;
      $display("Timeout: %s traffic never drained, words or credits still missing", phase);
    end
  endtask

  initial begin
    void'($urandom(51));
    rst       = 1'b1;
    link_fwd  = '0;
    out_ready = 1'b0;
    for (int i = 0; i < LINKS; i++) begin
      my_x[i] = `LF_X_W'(i + 1);
      my_y[i] = `LF_Y_W'(2);
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit(out_v, 1'b0, "v_o after reset");
    check_bit(drop, 1'b0, "drop_o after reset");
    for (int i = 0; i < LINKS; i++) begin
      check_bit(link_rev[i].credit, 1'b0, "credit pulse after reset");
    end

    // one channel alone, then all channels, then with stalls
    send_words(CHANS'(1), 6, 0, 1'b0);
    drain("single channel");
    send_words('1, 8, 0, 1'b0);
    drain("all channels");
    send_words('1, 12, 40, 1'b0);
    drain("back-pressure");

    // reads and misaddressed writes mixed in
    check_bit(drop, 1'b0, "drop_o before bad packets");
    send_words('1, 9, 25, 1'b1);
    drain("filtered");
    check_bit(drop, 1'b1, "drop_o after bad packets");

    $display("word errors %0d, bit errors %0d, timeouts %0d", word_errs, bit_errs, timeouts);
    if (word_errs == 0 && bit_errs == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+src
src/link_fifo_pkg.sv
src/relay_fifo.sv
src/rr_arbiter.sv
src/lane_merger.sv
src/link_endpoint.sv
src/link_to_fifo.sv
sim/link_to_fifo_tb.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= link_to_fifo_tb
VFLAGS   ?= --binary -j 0 -Wno-fatal
OBJ_DIR  ?= obj_dir

FILELIST := verilog.f
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard src/*.svh)
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(SIM) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
